/* src/flowPkg.sv */
package flowPkg;

  // ------------------------------------------------
  // Subsystem sizes
  // ------------------------------------------------

  // Number of merged input flows
  localparam int NumFlows = 3;

  // Width of one payload word
  localparam int DataWidth = 8;

  // Entries held by each input buffer
  localparam int FifoDepth = 4;

  // Bits needed to code a flow number
  localparam int SelectWidth = (NumFlows > 1) ? $clog2(NumFlows) : 1;

  // Buffer pointer and occupancy widths
  localparam int FifoPtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int FifoCountWidth = $clog2(FifoDepth + 1);

  // ------------------------------------------------
  // Vector types
  // ------------------------------------------------

  // One data word
  typedef logic [DataWidth-1:0] flowData;

  // A flow number, used for the mux select and for outFlow
  typedef logic [SelectWidth-1:0] flowSelect;

  // One bit per flow for valid and ready vectors
  typedef logic [NumFlows-1:0] flowMask;

  // Per-flow data bundle, entry i belongs to flow i
  typedef flowData [NumFlows-1:0] flowDataArray;

  // Buffer read and write pointers
  typedef logic [FifoPtrWidth-1:0] fifoPtr;

  // Buffer occupancy, 0 up to FifoDepth
  typedef logic [FifoCountWidth-1:0] fifoCount;

endpackage

/* src/flowFifo.sv */
module flowFifo (
  input  logic             clk,
  input  logic             reset,

  // Push side from the flow source
  input  logic             inValid,
  output logic             inReady,
  input  flowPkg::flowData inData,

  // Pop side toward the flow mux
  output logic             bufValid,
  input  logic             bufReady,
  output flowPkg::flowData bufData
);

  // Circular storage, payload only
  flowPkg::flowData storage [flowPkg::FifoDepth];

  flowPkg::fifoPtr wrPtr;
  flowPkg::fifoPtr rdPtr;
  flowPkg::fifoCount count;

  // Handshakes that complete on this edge
  logic push;
  logic pop;

  // Advance a pointer with wrap at the last entry
  function automatic flowPkg::fifoPtr nextPtr(input flowPkg::fifoPtr ptr);
    if (ptr == flowPkg::fifoPtr'(flowPkg::FifoDepth - 1)) begin
      return '0;
    end
    return ptr + flowPkg::fifoPtr'(1);
  endfunction

  // ------------------------------------------------
  // Status and handshake
  // ------------------------------------------------

  assign push = inValid && inReady;
  assign pop = bufValid && bufReady;

  // Accept while at least one entry is free
  assign inReady = (count != flowPkg::fifoCount'(flowPkg::FifoDepth));

  // Head word is presented from storage, never from inData
  assign bufValid = (count != '0);
  assign bufData = storage[rdPtr];

  // ------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      // Simultaneous push and pop leaves the count unchanged
      if (push && !pop) begin
        count <= count + flowPkg::fifoCount'(1);
      end else if (!push && pop) begin
        count <= count - flowPkg::fifoCount'(1);
      end
    end
  end

  // Storage write
  always_ff @(posedge clk) begin
    if (push) begin
      storage[wrPtr] <= inData;
    end
  end

endmodule

/* src/flowSelectControl.sv */
module flowSelectControl (
  input  logic               clk,
  input  logic               reset,

  // Per-flow head valid from the buffers
  input  flowPkg::flowMask   bufValid,

  // Selected stream as seen at the mux output
  input  logic               muxValid,
  input  logic               muxReady,

  // Binary select for the flow mux
  output flowPkg::flowSelect select
);

  // Search moves the select freely, hold freezes it on a stall
  typedef enum logic {
    ArbSearch,
    ArbHold
  } arbState;

  arbState state;
  arbState nextState;

  // Flow that completed the most recent transfer
  flowPkg::flowSelect lastServed;

  // Round-robin scan start and result
  flowPkg::flowSelect scanBase;
  flowPkg::flowSelect scanFlow;
  logic scanFound;

  logic transfer;
  logic stall;

  assign transfer = muxValid && muxReady;
  assign stall = muxValid && !muxReady;

  // On a transfer the current select is the flow just served
  assign scanBase = transfer ? select : lastServed;

  // ------------------------------------------------
  // Round-robin scan
  // ------------------------------------------------

  // First flow with a valid head after scanBase
  // The base flow itself comes last in the order
  always_comb begin : roundRobinScan
    int candidate;
    candidate = 0;
    scanFlow = select;
    scanFound = 1'b0;
    for (int step = 1; step <= flowPkg::NumFlows; step++) begin
      candidate = (int'(scanBase) + step) % flowPkg::NumFlows;
      if (!scanFound && bufValid[candidate]) begin
        scanFound = 1'b1;
        scanFlow = flowPkg::flowSelect'(candidate);
      end
    end
  end

  // ------------------------------------------------
  // State machine
  // ------------------------------------------------

  always_comb begin
    nextState = state;
    case (state)
      ArbSearch: begin
        if (stall) begin
          nextState = ArbHold;
        end
      end
      ArbHold: begin
        // Leave only once the held word has moved
        if (transfer) begin
          nextState = ArbSearch;
        end
      end
      default: nextState = ArbSearch;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ArbSearch;
      select <= '0;
      lastServed <= '0;
    end else begin
      state <= nextState;
      if (transfer) begin
        lastServed <= select;
      end
      // Search follows the scan unless stalled, hold waits for the transfer
      if ((state == ArbSearch) ? !stall : transfer) begin
        select <= scanFlow;
      end
    end
  end

endmodule

/* src/flowMuxSelectUnstable.sv */
module flowMuxSelectUnstable (
  // Binary flow number, kept below NumFlows by the controller
  input  flowPkg::flowSelect select,
  // Push side, one stream per flow
  output flowPkg::flowMask     bufReady,
  input  flowPkg::flowMask     bufValid,
  input  flowPkg::flowDataArray bufData,

  // Pop side toward the output register
  input  logic               muxReady,
  output logic               muxValid,
  output flowPkg::flowData   muxData
);

  // ------------------------------------------------
  // Ready steering
  // ------------------------------------------------

  // Only the selected buffer sees the downstream ready
  // All other buffers hold their head word
  always_comb begin
    bufReady = '0;
    bufReady[select] = muxReady;
  end

  // ------------------------------------------------
  // Valid and data steering
  // ------------------------------------------------

  // Follows the select directly, no stability of its own
  assign muxValid = bufValid[select];
  assign muxData = bufData[select];

endmodule

/* src/flowPopRegister.sv */
module flowPopRegister (
  input  logic               clk,
  input  logic               reset,

  // Push side from the flow mux
  input  logic               muxValid,
  output logic               muxReady,
  input  flowPkg::flowData   muxData,

  // Flow number of the word on the mux output
  input  flowPkg::flowSelect select,

  // Pop side to the external consumer
  output logic               outValid,
  input  logic               outReady,
  output flowPkg::flowData   outData,
  output flowPkg::flowSelect outFlow
);

  // Word captured on this edge
  logic capture;

  // ------------------------------------------------
  // Handshake
  // ------------------------------------------------

  // Free when empty or when the held word leaves this cycle
  // Keeps one word per cycle under full throughput
  assign muxReady = !outValid || outReady;

  assign capture = muxValid && muxReady;

  // ------------------------------------------------
  // Control state
  // ------------------------------------------------

  // Valid updates only when the slot is free
  // A stalled word keeps outValid high
  always_ff @(posedge clk) begin
    if (reset) begin
      outValid <= 1'b0;
    end else if (muxReady) begin
      outValid <= muxValid;
    end
  end

  // ------------------------------------------------
  // Payload
  // ------------------------------------------------

  // Data and origin move together
  // Both stay frozen while outReady is low
  always_ff @(posedge clk) begin
    if (capture) begin
      outData <= muxData;
      outFlow <= select;
    end
  end

endmodule

/* src/flowArbiterTop.sv */
module flowArbiterTop (
  input  logic                  clk,
  input  logic                  reset,

  // Input flows, one stream per bit
  input  flowPkg::flowMask      inValid,
  output flowPkg::flowMask      inReady,
  input  flowPkg::flowDataArray inData,

  // Merged output stream
  output logic                  outValid,
  input  logic                  outReady,
  output flowPkg::flowData      outData,
  output flowPkg::flowSelect    outFlow
);

  // Buffered flows toward the mux
  flowPkg::flowMask bufValid;
  flowPkg::flowMask bufReady;
  flowPkg::flowDataArray bufData;

  // Current flow choice
  flowPkg::flowSelect select;

  // Selected stream toward the output register
  logic muxValid;
  logic muxReady;
  flowPkg::flowData muxData;

  // ------------------------------------------------
  // Per-flow input buffers
  // ------------------------------------------------

  for (genvar i = 0; i < flowPkg::NumFlows; i++) begin : genFifo
    flowFifo fifo_i (
      .clk      (clk),
      .reset    (reset),
      .inValid  (inValid[i]),
      .inReady  (inReady[i]),
      .inData   (inData[i]),
      .bufValid (bufValid[i]),
      .bufReady (bufReady[i]),
      .bufData  (bufData[i])
    );
  end

  // ------------------------------------------------
  // Selection and steering
  // ------------------------------------------------

  // Watches only the mux output handshake for stalls
  flowSelectControl selectControl_i (
    .clk      (clk),
    .reset    (reset),
    .bufValid (bufValid),
    .muxValid (muxValid),
    .muxReady (muxReady),
    .select   (select)
  );

  flowMuxSelectUnstable mux_i (
    .select   (select),
    .bufReady (bufReady),
    .bufValid (bufValid),
    .bufData  (bufData),
    .muxReady (muxReady),
    .muxValid (muxValid),
    .muxData  (muxData)
  );

  // ------------------------------------------------
  // Output stage
  // ------------------------------------------------

  // Tags each word with the select value at capture
  flowPopRegister popRegister_i (
    .clk      (clk),
    .reset    (reset),
    .muxValid (muxValid),
    .muxReady (muxReady),
    .muxData  (muxData),
    .select   (select),
    .outValid (outValid),
    .outReady (outReady),
    .outData  (outData),
    .outFlow  (outFlow)
  );

endmodule

/* testbench/flowArbiter_asserts.sv */
module flowArbiterAsserts (
  input logic               clk,
  input logic               reset,

  // Top-level input side
  input flowPkg::flowMask   inValid,
  input flowPkg::flowMask   inReady,

  // Top-level output side
  input logic               outValid,
  input logic               outReady,
  input flowPkg::flowData   outData,
  input flowPkg::flowSelect outFlow,

  // Internal select and mux handshake
  input flowPkg::flowSelect select,
  input logic               muxValid,
  input logic               muxReady
);

  // Low bits of a word carry the per-flow sequence count
  localparam int SeqWidth = flowPkg::DataWidth - flowPkg::SelectWidth;
  // Cycles of full load before round-robin order is expected
  localparam int WarmUp = 16;

  int failCount = 0;

  // Words delivered so far per flow, also the next expected sequence
  int delivered [flowPkg::NumFlows];

  // Consecutive cycles with every input valid and outReady high
  int satCycles;

  // Flow of the latest output transfer
  flowPkg::flowSelect prevFlow;

  logic outXfer;

  assign outXfer = outValid && outReady;

  function automatic flowPkg::flowSelect nextFlow(input flowPkg::flowSelect flow);
    return flowPkg::flowSelect'((int'(flow) + 1) % flowPkg::NumFlows);
  endfunction

  // ------------------------------------------------
  // Per-flow trackers
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int f = 0; f < flowPkg::NumFlows; f++) begin
        delivered[f] <= 0;
      end
      satCycles <= 0;
      prevFlow <= '0;
    end else begin
      if (outXfer) begin
        delivered[outFlow] <= delivered[outFlow] + 1;
        prevFlow <= outFlow;
      end
      // Any idle input or stalled output restarts the warm-up
      if ((&inValid) && outReady) begin
        satCycles <= satCycles + 1;
      end else begin
        satCycles <= 0;
      end
    end
  end

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------

  // Empty buffers and an empty output register right after reset
  resetStateA: assert property (@(posedge clk)
    $fell(reset) |-> !outValid && (inReady == '1))
  else begin
    failCount++;
    $error("** Error %0t: wrong outValid or inReady after reset", $time);
  end

  // A stalled output word must not move
  outStableA: assert property (@(posedge clk) disable iff (reset)
    outValid && !outReady |=> outValid && $stable(outData) && $stable(outFlow))
  else begin
    failCount++;
    $error("** Error %0t: output changed while outReady was low", $time);
  end

  selectLockA: assert property (@(posedge clk) disable iff (reset)
    muxValid && !muxReady |=> $stable(select))
  else begin
    failCount++;
    $error("** Error %0t: select moved while the mux was stalled", $time);
  end

  // Tag bits name the origin, low bits follow that flow's count
  originOrderA: assert property (@(posedge clk) disable iff (reset)
    outXfer |->
      (outData[flowPkg::DataWidth-1 -: flowPkg::SelectWidth] == outFlow) &&
      (outData[SeqWidth-1:0] == SeqWidth'(delivered[outFlow])))
  else begin
    failCount++;
    $error("** Error %0t: word %0h on flow %0d out of origin or order", $time,
      outData, outFlow);
  end

  roundRobinA: assert property (@(posedge clk) disable iff (reset)
    outXfer && (satCycles >= WarmUp) |-> outFlow == nextFlow(prevFlow))
  else begin
    failCount++;
    $error("** Error %0t: flow %0d followed flow %0d under full load", $time,
      outFlow, prevFlow);
  end

endmodule

bind flowArbiterTop flowArbiterAsserts asserts_i (
  .clk      (clk),
  .reset    (reset),
  .inValid  (inValid),
  .inReady  (inReady),
  .outValid (outValid),
  .outReady (outReady),
  .outData  (outData),
  .outFlow  (outFlow),
  .select   (select),
  .muxValid (muxValid),
  .muxReady (muxReady)
);

/* testbench/flowArbiterTb.sv */
module flowArbiterTb;

  // ------------------------------------------------
  // Run length
  // ------------------------------------------------

  localparam int ClkPeriod = 4;
  localparam int ResetCycles = 5;
  localparam int SatCycles = 200;
  localparam int RandCycles = 400;
  localparam int DrainCycles = 60;
  localparam int TotalCycles = ResetCycles + SatCycles + RandCycles + DrainCycles;
  // Twice the planned run
  localparam int WatchdogTime = TotalCycles * ClkPeriod * 2;
  localparam int SeqWidth = flowPkg::DataWidth - flowPkg::SelectWidth;

  // Stimulus phases
  localparam int SatPhase = 0;
  localparam int RandPhase = 1;
  localparam int DrainPhase = 2;

  logic clk;
  logic reset;
  flowPkg::flowMask inValid;
  flowPkg::flowMask inReady;
  flowPkg::flowDataArray inData;
  logic outValid;
  logic outReady;
  flowPkg::flowData outData;
  flowPkg::flowSelect outFlow;

  // Words accepted per flow at the inputs
  int sentCount [flowPkg::NumFlows];
  int completionErrors;
  int assertErrors;

  flowArbiterTop dut_i (
    .clk      (clk),
    .reset    (reset),
    .inValid  (inValid),
    .inReady  (inReady),
    .inData   (inData),
    .outValid (outValid),
    .outReady (outReady),
    .outData  (outData),
    .outFlow  (outFlow)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Flow number in the top bits, sequence count below
  function automatic flowPkg::flowData makeWord(input int flow, input int count);
    logic [SeqWidth-1:0] seqBits;
    seqBits = SeqWidth'(count);
    return {flowPkg::flowSelect'(flow), seqBits};
  endfunction

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------

  // Called right after a rising edge, sees the pre-edge handshake
  task automatic stepInputs(input int phase);
    flowPkg::flowMask nextValid;
    flowPkg::flowDataArray nextData;
    logic pending;
    nextValid = inValid;
    nextData = inData;
    for (int f = 0; f < flowPkg::NumFlows; f++) begin
      if (inValid[f] && inReady[f]) begin
        sentCount[f]++;
      end
      // An offered word stays until the buffer takes it
      pending = inValid[f] && !inReady[f];
      if (!pending) begin
        case (phase)
          SatPhase: nextValid[f] = 1'b1;
          RandPhase: nextValid[f] = $urandom_range(0, 1);
          default: nextValid[f] = 1'b0;
        endcase
        nextData[f] = makeWord(f, sentCount[f]);
      end
    end
    inValid <= nextValid;
    inData <= nextData;
    outReady <= (phase == RandPhase) ? 1'($urandom_range(0, 1)) : 1'b1;
  endtask

  task automatic runPhase(input int phase, input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      stepInputs(phase);
    end
  endtask

  // Every accepted word must have left with its own flow number
  task automatic checkCompletion();
    for (int f = 0; f < flowPkg::NumFlows; f++) begin
      assert (sentCount[f] == dut_i.asserts_i.delivered[f])
      else begin
        completionErrors++;
        $display("** Error %0t: flow %0d accepted %0d words, delivered %0d", $time, f,
          sentCount[f], dut_i.asserts_i.delivered[f]);
      end
    end
    assert (!outValid)
    else begin
      completionErrors++;
      $display("** Error %0t: outValid still high after the drain phase", $time);
    end
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------

  initial begin : mainFlow
    void'($urandom(32'h8c28b574));
    reset = 1'b1;
    inValid = '0;
    inData = '0;
    outReady = 1'b0;
    completionErrors = 0;
    assertErrors = 0;
    for (int f = 0; f < flowPkg::NumFlows; f++) begin
      sentCount[f] = 0;
    end
    repeat (ResetCycles) @(posedge clk);
    reset <= 1'b0;
    runPhase(SatPhase, SatCycles);
    runPhase(RandPhase, RandCycles);
    runPhase(DrainPhase, DrainCycles);
    // Counters settle before the falling edge
    @(negedge clk);
    checkCompletion();
    assertErrors = dut_i.asserts_i.failCount;
    $display("Checks finished: %0d assertion failures, %0d completion errors",
      assertErrors, completionErrors);
    if ((assertErrors == 0) && (completionErrors == 0)) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(WatchdogTime);
    $display("Timeout: run not finished after %0d time units", WatchdogTime);
    $display("Regression failed");
    $finish;
  end

endmodule

/* src.f */
src/flowPkg.sv
src/flowFifo.sv
src/flowSelectControl.sv
src/flowMuxSelectUnstable.sv
src/flowPopRegister.sv
src/flowArbiterTop.sv
testbench/flowArbiter_asserts.sv
testbench/flowArbiterTb.sv
